// ==== slc3Core.f ====
+incdir+hw
hw/slc3_pkg.sv
hw/regFile.sv
hw/controlUnit.sv
hw/dataPath.sv
hw/slc3Core.sv
testbench/slc3Checker.sv
testbench/slc3Tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the simulation with Verilator, then judge the result from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module slc3Tb -f slc3Core.f -o slc3Sim &&
    ./obj_dir/slc3Sim > sim.log 2>&1 ||
    { echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Testbench failed" sim.log && exit 1 || exit 0

// ==== testbench/slc3Tb.sv ====
`timescale 1ns/1ps
`include "slc3_cfg.svh"

module slc3Tb;
    import slc3_pkg::*;

    localparam int          MemWords = 256;
    localparam logic [31:0] Seed     = 32'h67f6_2c00;
    localparam int          RunLimit = 200000;     // Cycles for the whole run

    typedef logic [`SLC3_WORD_W-1:0] word_t;

    logic        Clk;
    logic        Reset;
    logic        Run;
    logic        Continue = 1'b0;
    word_t       memRData = '0;
    word_t       memAddr;
    word_t       memWData;
    logic        memOeN;
    logic        memWeN;
    word_t       image [MemWords];     // Program as built, before the run
    word_t       mem [MemWords];
    logic [31:0] rngState;
    int          pulseCount;
    int          errorCount;
    int          instrCount;
    int          cycles;
    int          timeouts;
    logic        done;
    logic        stalled;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // One of the seven opcodes with random operands and cleared reserved fields
    function automatic word_t randomInstr(input logic [31:0] r);
        word_t w;
        w = r[15:0];
        case (r[31:16] % 7)
            0:       w[15:12] = OpAdd;
            1:       w[15:12] = OpAnd;
            2:       w[15:12] = OpLdr;
            3:       w[15:12] = OpStr;
            4:       w[15:12] = OpJmp;
            5:       w[15:12] = OpBr;
            default: w[15:12] = OpPse;
        endcase
        if ((w[15:12] == OpAdd || w[15:12] == OpAnd) && !w[5])
            w[4:3] = 2'b00;
        if (w[15:12] == OpJmp)
        begin
            w[11:9] = 3'b000;
            w[5:0]  = 6'b000000;
        end
        return w;
    endfunction

    task buildProgram;
        logic [2:0] dr;
        rngState = Seed;
        for (int a = 0; a < MemWords; a++)
        begin
            rngState = xorshift32(rngState);
            image[a] = randomInstr(rngState);
        end
        // Seed words for the registers at 0xE0..0xE7
        for (int n = 0; n < 8; n++)
        begin
            rngState       = xorshift32(rngState);
            image[224 + n] = rngState[15:0];
        end
        // Prologue LDR Rn, R0, #(n - 32)
        // R0 goes last because it is the base
        for (int n = 0; n < 8; n++)
        begin
            dr       = 3'(n + 1);
            image[n] = {OpLdr, dr, 3'b000, 3'b100, dr};
        end
    endtask

    initial
    begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    // Read data one cycle after the address, writes on every edge with memWeN low
    always @(posedge Clk)
    begin
        if (Reset)
            mem <= image;
        else
        begin
            if (!memWeN)
                mem[memAddr[7:0]] <= memWData;     // Address wraps on the low byte
            if (!memOeN)
                memRData <= mem[memAddr[7:0]];
        end
    end

    // Continue held high for three cycles out of every 40
    always @(posedge Clk)
    begin
        if (Reset)
        begin
            pulseCount <= 0;
            Continue   <= 1'b0;
        end
        else
        begin
            pulseCount <= (pulseCount == 39) ? 0 : pulseCount + 1;
            Continue   <= (pulseCount >= 37);
        end
    end

    //----------------------------------------------------------------------
    // Main sequence
    //----------------------------------------------------------------------
    initial
    begin
        Reset = 1'b1;
        Run   = 1'b0;
        buildProgram();
        repeat (10) @(posedge Clk);
        Reset <= 1'b0;
        repeat (5) @(posedge Clk);      // Core stays idle here
        Run <= 1'b1;
        cycles = 0;
        while (done !== 1'b1 && stalled !== 1'b1 && cycles < RunLimit)
        begin
            @(posedge Clk);
            cycles++;
        end
        if (cycles >= RunLimit)
            $display("Run did not complete its instructions within %0d cycles", RunLimit);
        timeouts = (done === 1'b1) ? 0 : 1;
        $display("Checked %0d instructions: %0d errors, %0d timeouts",
                 instrCount, errorCount, timeouts);
        if (done === 1'b1 && errorCount == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    slc3Core i_dut (
        .Clk      (Clk),
        .Reset    (Reset),
        .Run      (Run),
        .Continue (Continue),
        .memRData (memRData),
        .memAddr  (memAddr),
        .memWData (memWData),
        .memOeN   (memOeN),
        .memWeN   (memWeN)
    );

    slc3Checker i_checker (
        .Clk        (Clk),
        .Reset      (Reset),
        .Run        (Run),
        .Continue   (Continue),
        .memAddr    (memAddr),
        .memWData   (memWData),
        .memOeN     (memOeN),
        .memWeN     (memWeN),
        .image      (image),
        .errorCount (errorCount),
        .instrCount (instrCount),
        .done       (done),
        .stalled    (stalled)
    );

endmodule

// ==== testbench/slc3Checker.sv ====
`timescale 1ns/1ps
`include "slc3_cfg.svh"

module slc3Checker (
    input  logic                    Clk,
    input  logic                    Reset,
    input  logic                    Run,
    input  logic                    Continue,
    input  logic [`SLC3_WORD_W-1:0] memAddr,
    input  logic [`SLC3_WORD_W-1:0] memWData,
    input  logic                    memOeN,
    input  logic                    memWeN,
    input  logic [`SLC3_WORD_W-1:0] image [256],
    output int                      errorCount,
    output int                      instrCount,
    output logic                    done,
    output logic                    stalled
);
    import slc3_pkg::*;

    localparam int NumInstr = 2000;
    localparam int MaxGap   = 60;     // Longest allowed cycle gap between accesses

    typedef logic [`SLC3_WORD_W-1:0] word_t;

    word_t      mem [256];            // Model copy of memory
    word_t      regs [`SLC3_REG_COUNT];
    word_t      pc;
    word_t      expAddr;
    word_t      expData;
    logic [2:0] cc;                   // {N, Z, P}
    logic       expFetch;
    logic       expWrite;
    logic       started;
    logic       finished;
    logic       hung;
    logic       paused;
    logic       pulseHigh;            // Continue seen high during a pause
    logic       prevOeN;
    logic       prevWeN;
    int         errs;
    int         instrs;
    int         gap;

    task setReg(input logic [2:0] dr, input word_t value);
        regs[dr] = value;
        cc = value[15] ? 3'b100 : (value == '0) ? 3'b010 : 3'b001;
    endtask

    // Executes the fetched instruction and sets up the next expected access
    task stepModel;
        word_t ir;
        word_t opB;
        word_t addr;
        ir       = mem[pc[7:0]];
        pc       = pc + 16'd1;
        addr     = regs[ir[8:6]] + {{10{ir[5]}}, ir[5:0]};
        opB      = ir[5] ? {{11{ir[4]}}, ir[4:0]} : regs[ir[2:0]];
        expFetch = 1'b1;
        expWrite = 1'b0;
        case (ir[15:12])
            OpAdd: setReg(ir[11:9], regs[ir[8:6]] + opB);
            OpAnd: setReg(ir[11:9], regs[ir[8:6]] & opB);
            OpLdr:
            begin
                setReg(ir[11:9], mem[addr[7:0]]);
                expFetch = 1'b0;
            end
            OpStr:
            begin
                expData        = regs[ir[11:9]];
                mem[addr[7:0]] = expData;
                expFetch       = 1'b0;
                expWrite       = 1'b1;
            end
            OpJmp: pc = regs[ir[8:6]];
            OpBr:  if (|(ir[11:9] & cc)) pc = pc + {{7{ir[8]}}, ir[8:0]};
            OpPse: paused = 1'b1;
            default: ;      // Other opcodes decode as no-ops
        endcase
        expAddr = expFetch ? pc : addr;
    endtask

    task checkAccess(input logic isWrite);
        if (paused)
        begin
            $display("Access at %h during a pause, before a full Continue pulse", memAddr);
            errs++;
        end
        paused    = 1'b0;
        pulseHigh = 1'b0;
        if (isWrite != expWrite)
        begin
            if (isWrite)
                $display("Unexpected write at %h where the model expects a read", memAddr);
            else
                $display("Unexpected read at %h where the model expects a write", memAddr);
            errs++;
        end
        if (memAddr !== expAddr)
        begin
            $display("Mismatch memAddr: got %h, expected %h", memAddr, expAddr);
            errs++;
        end
        if (isWrite && expWrite && memWData !== expData)
        begin
            $display("Mismatch memWData: got %h, expected %h", memWData, expData);
            errs++;
        end
        if (!expFetch)
        begin
            expFetch = 1'b1;        // Data access done, fetch comes next
            expWrite = 1'b0;
            expAddr  = pc;
        end
        else if (instrs == NumInstr)
            finished = 1'b1;
        else
        begin
            instrs++;
            stepModel();
        end
    endtask

    always @(posedge Clk)
    begin
        if (Reset)
        begin
            regs      = '{default: '0};
            pc        = '0;
            cc        = 3'b010;
            expFetch  = 1'b1;
            expWrite  = 1'b0;
            expAddr   = '0;
            expData   = '0;
            started   = 1'b0;
            finished  = 1'b0;
            hung      = 1'b0;
            paused    = 1'b0;
            pulseHigh = 1'b0;
            errs      = 0;
            instrs    = 0;
            gap       = 0;
        end
        else if (!started)
        begin
            if (!memOeN || !memWeN)
            begin
                $display("Memory strobe active before Run");
                errs++;
            end
            if (Run)
            begin
                mem     = image;
                started = 1'b1;
            end
        end
        else if (!finished && !hung)
        begin
            if (paused && Continue)
                pulseHigh = 1'b1;
            else if (paused && pulseHigh)
                paused = 1'b0;      // High then low seen
            if (!memOeN && !memWeN)
            begin
                $display("Both memory strobes low at %h", memAddr);
                errs++;
            end
            if ((!memOeN && prevOeN) || (!memWeN && prevWeN))
            begin
                checkAccess(!memWeN);
                gap = 0;
            end
            else
            begin
                gap++;
                if (gap > MaxGap)
                begin
                    $display("No memory access for more than %0d cycles", MaxGap);
                    hung = 1'b1;
                end
            end
        end
        prevOeN = memOeN;
        prevWeN = memWeN;

        errorCount <= errs;
        instrCount <= instrs;
        done       <= finished;
        stalled    <= hung;
    end

endmodule

// ==== hw/slc3Core.sv ====
`timescale 1ns/1ps
`include "slc3_cfg.svh"

module slc3Core (
    input  logic                    Clk,
    input  logic                    Reset,
    input  logic                    Run,
    input  logic                    Continue,
    input  logic [`SLC3_WORD_W-1:0] memRData,
    output logic [`SLC3_WORD_W-1:0] memAddr,
    output logic [`SLC3_WORD_W-1:0] memWData,
    output logic                    memOeN,     // Active low
    output logic                    memWeN      // Active low
);
    import slc3_pkg::*;

    ctrl_t   ctrl;
    opcode_e opcode;
    logic    irBit5;
    logic    ben;

    controlUnit i_controlUnit (
        .Clk      (Clk),
        .Reset    (Reset),
        .Run      (Run),
        .Continue (Continue),
        .opcode   (opcode),
        .irBit5   (irBit5),
        .ben      (ben),
        .ctrl     (ctrl),
        .memOeN   (memOeN),
        .memWeN   (memWeN)
    );

    dataPath i_dataPath (
        .Clk      (Clk),
        .Reset    (Reset),
        .ctrl     (ctrl),
        .memRData (memRData),
        .memAddr  (memAddr),
        .memWData (memWData),
        .opcode   (opcode),
        .irBit5   (irBit5),
        .ben      (ben)
    );

endmodule

// ==== hw/dataPath.sv ====
`timescale 1ns/1ps
`include "slc3_cfg.svh"

module dataPath (
    input  logic                    Clk,
    input  logic                    Reset,
    input  slc3_pkg::ctrl_t         ctrl,
    input  logic [`SLC3_WORD_W-1:0] memRData,
    output logic [`SLC3_WORD_W-1:0] memAddr,
    output logic [`SLC3_WORD_W-1:0] memWData,
    output slc3_pkg::opcode_e       opcode,
    output logic                    irBit5,
    output logic                    ben
);
    import slc3_pkg::*;

    localparam int W = `SLC3_WORD_W;

    logic [W-1:0] pc, mar, mdr, ir;
    logic [2:0]   cc;                   // {N, Z, P}
    logic         benReg;
    logic         benNext;
    logic [W-1:0] bus;
    logic [W-1:0] sr1Data, sr2Data;
    logic [W-1:0] addr1, addr2, addrSum;
    logic [W-1:0] aluB, aluOut;
    logic [W-1:0] pcNext;
    logic [2:0]   ccNext;
    logic [`SLC3_REG_IDX_W-1:0] sr1Idx;

    //----------------------------------------------------------------------
    // Address adder and ALU
    //----------------------------------------------------------------------
    assign addr1 = (ctrl.addr1Sel == Addr1Pc) ? pc : sr1Data;

    always_comb
    begin
        case (ctrl.addr2Sel)
            Addr2Off9: addr2 = {{(W-9){ir[8]}}, ir[8:0]};
            Addr2Off6: addr2 = {{(W-6){ir[5]}}, ir[5:0]};
            default:   addr2 = '0;   // Zero and the spare code
        endcase
    end

    assign addrSum = addr1 + addr2;
    assign aluB    = ctrl.sr2Imm ? {{(W-5){ir[4]}}, ir[4:0]} : sr2Data;

    always_comb
    begin
        case (ctrl.aluOp)
            AluAdd:  aluOut = sr1Data + aluB;
            AluAnd:  aluOut = sr1Data & aluB;
            AluNot:  aluOut = ~sr1Data;
            default: aluOut = sr1Data;
        endcase
    end

    // Only one gate is on at a time
    always_comb
    begin
        if (ctrl.gatePc)          bus = pc;
        else if (ctrl.gateMdr)    bus = mdr;
        else if (ctrl.gateAlu)    bus = aluOut;
        else if (ctrl.gateMarMux) bus = addrSum;
        else                      bus = '0;
    end

    //----------------------------------------------------------------------
    // Registers
    //----------------------------------------------------------------------
    assign pcNext  = (ctrl.pcSel == PcAddr) ? addrSum : pc + 1'b1;
    assign ccNext  = {bus[W-1], bus == '0, !bus[W-1] && (bus != '0)};
    assign benNext = |(ir[11:9] & cc);

    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
        begin
            pc     <= '0;
            cc     <= 3'b010;       // Z set
            benReg <= 1'b0;
        end
        else
        begin
            if (ctrl.ldPc)  pc     <= pcNext;
            if (ctrl.ldCc)  cc     <= ccNext;
            if (ctrl.ldBen) benReg <= benNext;
        end
    end

    always_ff @(posedge Clk)
    begin
        if (ctrl.ldMar) mar <= bus;
        if (ctrl.ldIr)  ir  <= bus;
        if (ctrl.ldMdr) mdr <= ctrl.gateAlu ? bus : memRData;  // Store data vs read
    end

    // Decode sees the value being loaded
    assign ben    = ctrl.ldBen ? benNext : benReg;
    assign opcode = opcode_e'(ir[15:12]);
    assign irBit5 = ir[5];

    assign memAddr  = mar;
    assign memWData = mdr;

    assign sr1Idx = ctrl.sr1FromDr ? ir[11:9] : ir[8:6];

    regFile i_regFile (
        .Clk     (Clk),
        .Reset   (Reset),
        .sr1     (sr1Idx),
        .sr2     (ir[2:0]),
        .dr      (ir[11:9]),
        .wrData  (bus),
        .wrEn    (ctrl.ldReg),
        .sr1Data (sr1Data),
        .sr2Data (sr2Data)
    );

endmodule

// ==== hw/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
    input  logic              Clk,
    input  logic              Reset,
    input  logic              Run,
    input  logic              Continue,
    input  slc3_pkg::opcode_e opcode,
    input  logic              irBit5,
    input  logic              ben,
    output slc3_pkg::ctrl_t   ctrl,
    output logic              memOeN,
    output logic              memWeN
);
    import slc3_pkg::*;

    typedef enum logic [4:0] {
        Halted,
        Fetch,      // MAR <- PC, PC <- PC + 1
        Read1,
        Read2,      // MDR <- M[MAR]
        LoadIr,
        Decode,
        ExAdd,
        ExAnd,
        ExJmp,
        ExBr,
        LdrAddr,
        LdrRead1,
        LdrRead2,
        LdrWrite,
        StrAddr,
        StrMdr,
        StrWrite1,
        StrWrite2,
        Pause1,
        Pause2
    } state_e;

    state_e state;
    state_e nextState;

    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
            state <= Halted;
        else
            state <= nextState;
    end

    //----------------------------------------------------------------------
    // Next state
    //----------------------------------------------------------------------
    always_comb
    begin
        nextState = state;
        unique case (state)
            Halted:   if (Run) nextState = Fetch;
            Fetch:    nextState = Read1;
            Read1:    nextState = Read2;
            Read2:    nextState = LoadIr;
            LoadIr:   nextState = Decode;
            Decode:
            begin
                case (opcode)
                    OpAdd:   nextState = ExAdd;
                    OpAnd:   nextState = ExAnd;
                    OpLdr:   nextState = LdrAddr;
                    OpStr:   nextState = StrAddr;
                    OpJmp:   nextState = ExJmp;
                    OpBr:    nextState = ben ? ExBr : Fetch;  // Not taken skips execute
                    OpPse:   nextState = Pause1;
                    default: nextState = Fetch;
                endcase
            end
            LdrAddr:  nextState = LdrRead1;
            LdrRead1: nextState = LdrRead2;
            LdrRead2: nextState = LdrWrite;
            StrAddr:  nextState = StrMdr;
            StrMdr:   nextState = StrWrite1;
            StrWrite1: nextState = StrWrite2;
            // Wait for a full high-then-low pulse on Continue
            Pause1:   if (Continue) nextState = Pause2;
            Pause2:   if (!Continue) nextState = Fetch;
            ExAdd, ExAnd, ExJmp, ExBr, LdrWrite, StrWrite2: nextState = Fetch;
            default:  nextState = Halted;
        endcase
    end

    //----------------------------------------------------------------------
    // Control word and memory strobes
    //----------------------------------------------------------------------
    always_comb
    begin
        ctrl          = '0;
        ctrl.pcSel    = PcInc;
        ctrl.addr1Sel = Addr1Base;
        ctrl.addr2Sel = Addr2Zero;
        ctrl.aluOp    = AluAdd;
        memOeN        = 1'b1;
        memWeN        = 1'b1;

        case (state)
            Fetch:
            begin
                ctrl.gatePc = 1'b1;
                ctrl.ldMar  = 1'b1;
                ctrl.ldPc   = 1'b1;
            end
            Read1, LdrRead1:
                memOeN = 1'b0;
            Read2, LdrRead2:
            begin
                memOeN     = 1'b0;
                ctrl.ldMdr = 1'b1;     // Sampled at end of second cycle
            end
            LoadIr:
            begin
                ctrl.gateMdr = 1'b1;
                ctrl.ldIr    = 1'b1;
            end
            Decode:
                ctrl.ldBen = 1'b1;
            ExAdd, ExAnd:
            begin
                ctrl.sr2Imm  = irBit5;
                ctrl.aluOp   = (state == ExAnd) ? AluAnd : AluAdd;
                ctrl.gateAlu = 1'b1;
                ctrl.ldReg   = 1'b1;
                ctrl.ldCc    = 1'b1;
            end
            ExJmp:
            begin
                ctrl.pcSel = PcAddr;   // Base + 0
                ctrl.ldPc  = 1'b1;
            end
            ExBr:
            begin
                ctrl.addr1Sel = Addr1Pc;
                ctrl.addr2Sel = Addr2Off9;
                ctrl.pcSel    = PcAddr;
                ctrl.ldPc     = 1'b1;
            end
            LdrAddr, StrAddr:
            begin
                ctrl.addr2Sel   = Addr2Off6;
                ctrl.gateMarMux = 1'b1;
                ctrl.ldMar      = 1'b1;
            end
            LdrWrite:
            begin
                ctrl.gateMdr = 1'b1;
                ctrl.ldReg   = 1'b1;
                ctrl.ldCc    = 1'b1;
            end
            StrMdr:
            begin
                ctrl.sr1FromDr = 1'b1;  // Source register sits in DR field
                ctrl.aluOp     = AluPassA;
                ctrl.gateAlu   = 1'b1;
                ctrl.ldMdr     = 1'b1;
            end
            StrWrite1, StrWrite2:
                memWeN = 1'b0;
            default: ;
        endcase
    end

endmodule

// ==== hw/regFile.sv ====
`timescale 1ns/1ps
`include "slc3_cfg.svh"

module regFile (
    input  logic                       Clk,
    input  logic                       Reset,
    input  logic [`SLC3_REG_IDX_W-1:0] sr1,
    input  logic [`SLC3_REG_IDX_W-1:0] sr2,
    input  logic [`SLC3_REG_IDX_W-1:0] dr,
    input  logic [`SLC3_WORD_W-1:0]    wrData,
    input  logic                       wrEn,
    output logic [`SLC3_WORD_W-1:0]    sr1Data,
    output logic [`SLC3_WORD_W-1:0]    sr2Data
);

    logic [`SLC3_WORD_W-1:0] regs [`SLC3_REG_COUNT];

    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
        begin
            for (int i = 0; i < `SLC3_REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (wrEn)
            regs[dr] <= wrData;
    end

    // Reads are combinational, no bypass
    assign sr1Data = regs[sr1];
    assign sr2Data = regs[sr2];

endmodule

// ==== hw/slc3_pkg.sv ====
package slc3_pkg;

    // IR[15:12] encodings of the supported subset
    typedef enum logic [3:0] {
        OpBr  = 4'b0000,
        OpAdd = 4'b0001,
        OpAnd = 4'b0101,
        OpLdr = 4'b0110,
        OpStr = 4'b0111,
        OpJmp = 4'b1100,
        OpPse = 4'b1101
    } opcode_e;

    typedef enum logic [1:0] {
        AluAdd,
        AluAnd,
        AluNot,
        AluPassA    // SR1 straight through, store path
    } aluOp_e;

    typedef enum logic [1:0] {
        PcInc,      // PC + 1
        PcAddr      // Address adder result
    } pcSel_e;

    typedef enum logic {
        Addr1Base,  // SR1 as base register
        Addr1Pc
    } addr1Sel_e;

    typedef enum logic [1:0] {
        Addr2Zero,
        Addr2Off9,
        Addr2Off6,
        Addr2Unused
    } addr2Sel_e;

    // Everything the datapath takes from the sequencer
    typedef struct packed {
        logic      ldMar;
        logic      ldMdr;
        logic      ldIr;
        logic      ldBen;
        logic      ldCc;
        logic      ldReg;
        logic      ldPc;
        logic      gatePc;
        logic      gateMdr;
        logic      gateAlu;
        logic      gateMarMux;
        pcSel_e    pcSel;
        addr1Sel_e addr1Sel;
        addr2Sel_e addr2Sel;
        logic      sr1FromDr;   // Read IR[11:9] on SR1
        logic      sr2Imm;      // imm5 instead of SR2
        aluOp_e    aluOp;
    } ctrl_t;

endpackage

// ==== hw/slc3_cfg.svh ====
`ifndef SLC3_CFG_SVH
`define SLC3_CFG_SVH

// Machine word, used for both data and addresses
`define SLC3_WORD_W 16

// General register file
`define SLC3_REG_COUNT 8
`define SLC3_REG_IDX_W 3    // log2 of the register count

`endif
